//--- noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Flit payload width in bits.
`define NOC_FLIT_WIDTH 16

// Number of virtual channels on the input port.
`define NOC_VCS 2

// Entries in each per-VC FIFO.
`define NOC_FIFO_DEPTH 4

// Fill level at which almost_full rises and vc_ready drops.
`define NOC_FIFO_THRESHOLD 3

`endif

//--- noc_pkg.sv
`default_nettype none

`include "noc_config.svh"

package noc_pkg;

  // Flit payload as carried on the link.
  typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

  // Index of one virtual channel.
  typedef logic [$clog2(`NOC_VCS)-1:0] vc_t;

  // One bit per VC, for valid, ready and the status flags.
  typedef logic [`NOC_VCS-1:0] vc_mask_t;

  // FIFO fill level, 0 up to and including the depth.
  typedef logic [$clog2(`NOC_FIFO_DEPTH+1)-1:0] fifo_count_t;

  typedef enum logic {
    ARB_IDLE = 1'b0,  // Free to pick a new VC.
    ARB_HOLD = 1'b1   // Grant held while output stalls.
  } arb_state_t;

endpackage

`default_nettype wire

//--- noc_flit_if.sv
`default_nettype none
`timescale 1ns/1ps

interface noc_flit_if
  import noc_pkg::*;
();
  vc_mask_t valid;     // At most one bit set.
  vc_mask_t ready;     // Per-VC not full.
  vc_mask_t vc_ready;  // Per-VC not almost full.
  flit_t    flit;      // Shared by all VCs.

  // Channels that transfer a flit on this edge.
  function automatic vc_mask_t get_ack();
    return valid & ready;
  endfunction

  modport sender (
    output valid,
    output flit,
    input  ready,
    input  vc_ready,
    import get_ack
  );

  modport receiver (
    input  valid,
    input  flit,
    output ready,
    output vc_ready,
    import get_ack
  );

endinterface

`default_nettype wire

//--- noc_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "noc_config.svh"

module noc_fifo
  import noc_pkg::*;
(
  input  var logic  i_clk,
  input  var logic  i_rst_n,
  input  var logic  i_clear,
  input  var logic  i_push,
  input  var flit_t i_data,
  input  var logic  i_pop,
  output var flit_t o_data,
  output var logic  o_empty,
  output var logic  o_almost_full,
  output var logic  o_full
);
  localparam int          PTR_WIDTH    = $clog2(`NOC_FIFO_DEPTH);
  localparam int          LAST_ENTRY   = `NOC_FIFO_DEPTH - 1;
  localparam fifo_count_t FULL_COUNT   = fifo_count_t'(`NOC_FIFO_DEPTH);
  localparam fifo_count_t ALMOST_COUNT = fifo_count_t'(`NOC_FIFO_THRESHOLD);

  flit_t                mem [`NOC_FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  fifo_count_t          count;
  fifo_count_t          count_next;
  logic                 do_push;
  logic                 do_pop;

  // Pointer step with wrap for any depth.
  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (int'(ptr) == LAST_ENTRY) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = i_push && !o_full;   // Drop push when full.
  assign do_pop  = i_pop && !o_empty;   // Drop pop when empty.
  assign o_data  = mem[rd_ptr];

  always_comb begin
    if (i_clear) begin
      count_next = '0;
    end else begin
      unique case ({do_push, do_pop})
        2'b10:   count_next = count + 1'b1;
        2'b01:   count_next = count - 1'b1;
        default: count_next = count;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      o_empty       <= 1'b1;
      o_almost_full <= 1'b0;
      o_full        <= 1'b0;
    end else begin
      if (i_clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (do_push) wr_ptr <= ptr_inc(wr_ptr);
        if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      end
      count         <= count_next;
      o_empty       <= (count_next == '0);  // Flags follow next count.
      o_almost_full <= (count_next >= ALMOST_COUNT);
      o_full        <= (count_next == FULL_COUNT);
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push && !i_clear) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

`default_nettype wire

//--- noc_flit_if_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "noc_config.svh"

module noc_flit_if_fifo
  import noc_pkg::*;
(
  input  var logic                    i_clk,
  input  var logic                    i_rst_n,
  input  var logic                    i_clear,
  noc_flit_if.receiver                receiver_if,
  input  var vc_mask_t                i_pop,
  output var flit_t [`NOC_VCS-1:0]    o_head_flit,
  output var vc_mask_t                o_empty,
  output var vc_mask_t                o_almost_full,
  output var vc_mask_t                o_full
);
  vc_mask_t empty;
  vc_mask_t almost_full;
  vc_mask_t full;
  vc_mask_t push;

  // Only the channel named by valid takes the shared flit.
  assign push = receiver_if.get_ack();

  always_comb begin
    receiver_if.ready    = ~full;
    receiver_if.vc_ready = ~almost_full;  // Early warning to the sender.
  end

  assign o_empty       = empty;
  assign o_almost_full = almost_full;
  assign o_full        = full;

  for (genvar i = 0; i < `NOC_VCS; i++) begin : g_vc
    noc_fifo u_fifo (
      .i_clk         (i_clk           ),
      .i_rst_n       (i_rst_n         ),
      .i_clear       (i_clear         ),
      .i_push        (push[i]         ),
      .i_data        (receiver_if.flit),
      .i_pop         (i_pop[i]        ),
      .o_data        (o_head_flit[i]  ),
      .o_empty       (empty[i]        ),
      .o_almost_full (almost_full[i]  ),
      .o_full        (full[i]         )
    );
  end

endmodule

`default_nettype wire

//--- noc_vc_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "noc_config.svh"

module noc_vc_arbiter
  import noc_pkg::*;
(
  input  var logic                 i_clk,
  input  var logic                 i_rst_n,
  input  var vc_mask_t             i_empty,
  input  var flit_t [`NOC_VCS-1:0] i_head_flit,
  output var vc_mask_t             o_pop,
  output var logic                 o_valid,
  output var vc_t                  o_vc,
  output var flit_t                o_flit,
  input  var logic                 i_ready
);
  arb_state_t state;
  vc_t        rr_ptr;
  vc_t        hold_vc;
  vc_t        pick_vc;
  logic       pick_found;
  vc_t        sel_vc;
  logic       sel_valid;
  logic       accept;

  function automatic vc_t vc_after(input vc_t vc);
    return vc_t'((int'(vc) + 1) % `NOC_VCS);
  endfunction

  // First non-empty VC at or after the pointer.
  always_comb begin
    vc_t idx;
    pick_found = 1'b0;
    pick_vc    = rr_ptr;
    for (int i = 0; i < `NOC_VCS; i++) begin
      idx = vc_t'((int'(rr_ptr) + i) % `NOC_VCS);
      if (!pick_found && !i_empty[idx]) begin
        pick_found = 1'b1;
        pick_vc    = idx;
      end
    end
  end

  always_comb begin
    if (state == ARB_HOLD) begin
      sel_vc    = hold_vc;
      sel_valid = !i_empty[hold_vc];  // Drops if a clear emptied it.
    end else begin
      sel_vc    = pick_vc;
      sel_valid = pick_found;
    end
  end

  assign accept  = sel_valid && i_ready;
  assign o_valid = sel_valid;
  assign o_vc    = sel_vc;
  assign o_flit  = i_head_flit[sel_vc];

  always_comb begin
    o_pop = '0;
    if (accept) o_pop[sel_vc] = 1'b1;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= ARB_IDLE;
      rr_ptr  <= '0;
      hold_vc <= '0;
    end else begin
      if (accept) rr_ptr <= vc_after(sel_vc);  // Next search starts past winner.
      unique case (state)
        ARB_IDLE: begin
          if (sel_valid && !i_ready) begin
            state   <= ARB_HOLD;
            hold_vc <= sel_vc;
          end
        end
        ARB_HOLD: begin
          if (accept || !sel_valid) state <= ARB_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- noc_input_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "noc_config.svh"

module noc_input_buffer
  import noc_pkg::*;
(
  input  var logic     i_clk,
  input  var logic     i_rst_n,
  input  var logic     i_clear,
  input  var vc_mask_t i_valid,
  input  var flit_t    i_flit,
  output var vc_mask_t o_ready,
  output var vc_mask_t o_vc_ready,
  output var vc_mask_t o_empty,
  output var vc_mask_t o_almost_full,
  output var vc_mask_t o_full,
  output var logic     o_valid,
  output var vc_t      o_vc,
  output var flit_t    o_flit,
  input  var logic     i_ready
);
  flit_t [`NOC_VCS-1:0] head_flit;
  vc_mask_t             empty;
  vc_mask_t             pop;

  noc_flit_if flit_if ();

  // Inbound link sender side comes straight from the ports.
  assign flit_if.valid = i_valid;
  assign flit_if.flit  = i_flit;
  assign o_ready       = flit_if.ready;
  assign o_vc_ready    = flit_if.vc_ready;
  assign o_empty       = empty;

  noc_flit_if_fifo u_flit_if_fifo (
    .i_clk         (i_clk        ),
    .i_rst_n       (i_rst_n      ),
    .i_clear       (i_clear      ),
    .receiver_if   (flit_if      ),
    .i_pop         (pop          ),
    .o_head_flit   (head_flit    ),
    .o_empty       (empty        ),
    .o_almost_full (o_almost_full),
    .o_full        (o_full       )
  );

  noc_vc_arbiter u_vc_arbiter (
    .i_clk       (i_clk    ),
    .i_rst_n     (i_rst_n  ),
    .i_empty     (empty    ),
    .i_head_flit (head_flit),
    .o_pop       (pop      ),
    .o_valid     (o_valid  ),
    .o_vc        (o_vc     ),
    .o_flit      (o_flit   ),
    .i_ready     (i_ready  )
  );

endmodule

`default_nettype wire

//--- noc_input_buffer_assert.sv
`default_nettype none
`timescale 1ns/1ps

module noc_input_buffer_assert
  import noc_pkg::*;
(
  input var logic     i_clk,
  input var logic     i_rst_n,
  input var vc_mask_t i_valid,
  input var logic     i_ready,
  input var logic     o_valid,
  input var vc_t      o_vc,
  input var flit_t    o_flit,
  input var vc_mask_t o_ready,
  input var vc_mask_t o_full
);

  // A clear may drop o_valid while stalled.
  a_stall_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && !i_ready) |=> (!o_valid || ($stable(o_vc) && $stable(o_flit))))
    else $error("o_vc or o_flit changed while the output was stalled");

  // Full only rises on an edge where that VC took a flit.
  a_full_on_push: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_full & $past(o_ready) & ~$past(i_valid)) == '0)
    else $error("o_full rose on a VC that took no flit");

  a_idle_after_reset: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> !o_valid)
    else $error("o_valid high in the first cycle after reset");

endmodule

bind noc_input_buffer noc_input_buffer_assert u_assert (.*);

`default_nettype wire

//--- tb_noc_input_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "noc_config.svh"

module tb_noc_input_buffer
  import noc_pkg::*;
();
  typedef struct packed {
    vc_t   vc;
    flit_t flit;
  } entry_t;

  logic     i_clk;
  logic     i_rst_n;
  logic     i_clear;
  vc_mask_t i_valid;
  flit_t    i_flit;
  logic     i_ready;
  vc_mask_t o_ready;
  vc_mask_t o_vc_ready;
  vc_mask_t o_empty;
  vc_mask_t o_almost_full;
  vc_mask_t o_full;
  logic     o_valid;
  vc_t      o_vc;
  flit_t    o_flit;

  entry_t   model_q[$];  // Expected flits in push order.
  vc_t      rr_ptr;      // Where the next search starts.
  string    op_q[$];
  int       a1_q[$];
  flit_t    a2_q[$];
  vc_mask_t mask_q[$];
  int       errors = 0;
  int       cycles = 0;
  int       cycle_limit = 0;

  noc_input_buffer uut (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: test data not finished after %0d cycles", cycles);
      $display("Errors: %0d", errors);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_vc(input string name, input vc_t exp, input vc_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_mask(input string name, input vc_mask_t exp, input vc_mask_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // Index of the flit the round-robin rule puts on the output, -1 if none.
  function automatic int model_pick();
    vc_t idx;
    for (int i = 0; i < `NOC_VCS; i++) begin
      idx = vc_t'((int'(rr_ptr) + i) % `NOC_VCS);
      foreach (model_q[j]) begin
        if (model_q[j].vc == idx) return j;
      end
    end
    return -1;
  endfunction

  // Channels holding at least the threshold of expected flits.
  function automatic vc_mask_t model_almost_full();
    vc_mask_t res;
    int       fill [`NOC_VCS];
    res = '0;
    foreach (fill[k]) fill[k] = 0;
    foreach (model_q[j]) fill[model_q[j].vc]++;
    foreach (fill[k]) res[k] = (fill[k] >= `NOC_FIFO_THRESHOLD);
    return res;
  endfunction

  task automatic check_output(output int pos);
    pos = model_pick();
    check_bit("o_valid", pos >= 0, o_valid);
    if (pos >= 0) begin
      check_vc("o_vc", model_q[pos].vc, o_vc);
      check_flit("o_flit", model_q[pos].flit, o_flit);
    end
  endtask

  task automatic push(input vc_t vc, input flit_t flit);
    i_valid     = '0;
    i_valid[vc] = 1'b1;
    i_flit      = flit;
    @(negedge i_clk);
    while (!o_ready[vc]) @(negedge i_clk);  // Sender holds valid.
    @(posedge i_clk);
    #2;
    i_valid = '0;
    model_q.push_back(entry_t'{vc, flit});
  endtask

  task automatic drain(input int count, input bit gaps);
    int done;
    int pos;
    done = 0;
    while (done < count) begin
      i_ready = gaps ? (($urandom % 3) != 0) : 1'b1;
      @(negedge i_clk);
      check_output(pos);
      if (pos < 0) begin
        errors++;
        $display("Drain wanted %0d more flits but none are expected", count - done);
        done = count;
      end else if (i_ready) begin
        rr_ptr = vc_t'((int'(model_q[pos].vc) + 1) % `NOC_VCS);
        model_q.delete(pos);
        done++;
      end
      @(posedge i_clk);
      #2;
    end
    i_ready = 1'b0;
  endtask

  task automatic stall(input int n);
    int pos;
    i_ready = 1'b0;
    repeat (n) begin
      @(negedge i_clk);
      check_output(pos);  // Grant must not move.
      @(posedge i_clk);
      #2;
    end
  endtask

  task automatic clear_all();
    i_clear = 1'b1;
    @(posedge i_clk);
    #2;
    i_clear = 1'b0;
    model_q.delete();
    @(negedge i_clk);
    check_mask("o_empty", '1, o_empty);
    check_bit("o_valid", 1'b0, o_valid);
    @(posedge i_clk);
    #2;
  endtask

  task automatic check_flags(input int flag, input vc_mask_t mask);
    @(negedge i_clk);
    case (flag)
      0: check_mask("o_empty", mask, o_empty);
      1: check_mask("o_almost_full", mask, o_almost_full);
      2: check_mask("o_full", mask, o_full);
      3: check_mask("o_ready", mask, o_ready);
      4: begin
        check_mask("o_vc_ready", mask, o_vc_ready);
        check_mask("o_almost_full", model_almost_full(), o_almost_full);
      end
      default: begin
        errors++;
        $display("Unknown flag selector %0d in the test data", flag);
      end
    endcase
    @(posedge i_clk);
    #2;
  endtask

  task automatic load_testdata(output bit ok);
    int       fd;
    int       code;
    string    op;
    string    line;
    int       a1;
    flit_t    a2;
    vc_mask_t mask;
    fd = $fopen("noc_testdata.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", op);
        if (code == 1 && op.len() > 0 && op[0] == "#") begin
          code = $fgets(line, fd);  // Skip comment text.
        end else if (code == 1) begin
          code = $fscanf(fd, "%d %h %b", a1, a2, mask);
          if (code == 3) begin
            op_q.push_back(op);
            a1_q.push_back(a1);
            a2_q.push_back(a2);
            mask_q.push_back(mask);
          end
        end
      end
      $fclose(fd);
      cycle_limit = 40 * op_q.size();
    end
  endtask

  task automatic run_tests();
    repeat (4) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;
    foreach (op_q[i]) begin
      case (op_q[i])
        "PUSH":       push(vc_t'(a1_q[i]), a2_q[i]);
        "DRAIN":      drain(a1_q[i], a2_q[i] != '0);
        "STALL":      stall(a1_q[i]);
        "CLEAR":      clear_all();
        "CHECKFLAGS": check_flags(a1_q[i], mask_q[i]);
        default: begin
          errors++;
          $display("Unknown operation %s in the test data", op_q[i]);
        end
      endcase
    end
  endtask

  initial begin
    bit ok;
    i_rst_n = 1'b0;
    i_clear = 1'b0;
    i_valid = '0;
    i_flit  = '0;
    i_ready = 1'b0;
    rr_ptr  = '0;
    void'($urandom(34));
    load_testdata(ok);
    if (!ok) begin
      $display("Could not open the test data file noc_testdata.txt");
      $display("Testbench failed");
      $finish;
    end else begin
      run_tests();
      $display("Errors: %0d", errors);
      if (errors == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
noc_pkg.sv
noc_flit_if.sv
noc_fifo.sv
noc_flit_if_fifo.sv
noc_vc_arbiter.sv
noc_input_buffer.sv
noc_input_buffer_assert.sv
tb_noc_input_buffer.sv

//--- noc_testdata.txt
# op a1 a2 mask: PUSH vc flit, DRAIN count gaps, STALL cycles, CLEAR, CHECKFLAGS flag mask
# flag: 0 empty, 1 almost_full, 2 full, 3 ready, 4 vc_ready; unused columns are 0
CHECKFLAGS 0 0 11
CHECKFLAGS 3 0 11
CHECKFLAGS 4 0 11
PUSH 0 a001 00
PUSH 0 a002 00
PUSH 0 a003 00
CHECKFLAGS 4 0 10
PUSH 0 a004 00
CHECKFLAGS 2 0 01
CHECKFLAGS 3 0 10
PUSH 1 b001 00
PUSH 1 b002 00
PUSH 1 b003 00
STALL 3 0 00
DRAIN 6 0 00
PUSH 1 b004 00
PUSH 1 b005 00
DRAIN 3 1 00
PUSH 0 c001 00
PUSH 1 c002 00
CLEAR 0 0 00
PUSH 1 d001 00
DRAIN 1 1 00
CHECKFLAGS 0 0 11
